/* compile.f */
+incdir+test
hw/sm83_alu_pkg.sv
hw/alu_fifo.sv
hw/alu_shifter.sv
hw/alu_adder_cla.sv
hw/alu_apb_regs.sv
hw/alu_core.sv
hw/alu_subsystem_top.sv
test/tb_alu_subsystem.sv

/* hw/alu_adder_cla.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_adder_cla (
	input  logic [7:0] a,
	input  logic [7:0] b,	// Caller complements for subtract
	input  logic       cin,
	output logic [7:0] sum,
	output logic       half_carry,	// Carry out of bit 3
	output logic       carry	// Carry out of bit 7
);

	logic [7:0] g;	// Generate per bit
	logic [7:0] p;	// Propagate per bit
	logic [4:1] c_lo;
	logic [4:1] c_hi;

	// Flat lookahead over one nibble
	function automatic logic [4:1] cla_group(
		input logic [3:0] gg,
		input logic [3:0] pp,
		input logic       ci
	);
		logic [4:1] cc;
		cc[1] = gg[0] | (pp[0] & ci);
		cc[2] = gg[1] | (pp[1] & gg[0]) | (pp[1] & pp[0] & ci);
		cc[3] = gg[2] | (pp[2] & gg[1]) | (pp[2] & pp[1] & gg[0])
			| (pp[2] & pp[1] & pp[0] & ci);
		cc[4] = gg[3] | (pp[3] & gg[2]) | (pp[3] & pp[2] & gg[1])
			| (pp[3] & pp[2] & pp[1] & gg[0]) | (pp[3] & pp[2] & pp[1] & pp[0] & ci);
		return cc;
	endfunction

	assign g = a & b;
	assign p = a ^ b;

	assign c_lo = cla_group(g[3:0], p[3:0], cin);
	assign c_hi = cla_group(g[7:4], p[7:4], c_lo[4]);	// Chained on the nibble carry

	assign sum        = p ^ {c_hi[3:1], c_lo[4:1], cin};	// Carry into each bit
	assign half_carry = c_lo[4];
	assign carry      = c_hi[4];

endmodule

`default_nettype wire

/* hw/alu_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_apb_regs (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [sm83_alu_pkg::APB_ADDR_W-1:0] paddr,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [sm83_alu_pkg::APB_DATA_W-1:0] pwdata,
	output logic [sm83_alu_pkg::APB_DATA_W-1:0] prdata,
	output logic                                pready,
	output logic                                pslverr,
	output logic                                cmd_push,
	output sm83_alu_pkg::alu_cmd_t              cmd_data,
	input  logic                                cmd_full,
	input  logic [sm83_alu_pkg::FIFO_CNT_W-1:0] cmd_count,
	output logic                                res_pop,
	input  sm83_alu_pkg::alu_res_t              res_data,
	input  logic                                res_empty,
	input  logic [sm83_alu_pkg::FIFO_CNT_W-1:0] res_count
);

	logic access;	// Second APB phase
	logic wr_cmd;
	logic wr_bad;	// Write to a read-only or unmapped offset
	logic rd_result;
	logic rd_status;

	assign access    = psel & penable;
	assign wr_cmd    = access & pwrite & (paddr == sm83_alu_pkg::REG_CMD);
	assign wr_bad    = access & pwrite & (paddr != sm83_alu_pkg::REG_CMD);
	assign rd_result = access & ~pwrite & (paddr == sm83_alu_pkg::REG_RESULT);
	assign rd_status = access & ~pwrite & (paddr == sm83_alu_pkg::REG_STATUS);

	assign pready   = 1'b1;	// Zero wait states
	assign pslverr  = wr_bad | (wr_cmd & cmd_full);	// Full FIFO drops the command
	assign cmd_push = wr_cmd & ~cmd_full;
	assign res_pop  = rd_result & ~res_empty;	// Empty read is harmless

	// Command word unpacked straight from the write data
	always_comb begin
		cmd_data.a   = pwdata[7:0];
		cmd_data.b   = pwdata[15:8];
		cmd_data.op  = sm83_alu_pkg::alu_op_e'(pwdata[20:16]);
		cmd_data.sel = pwdata[23:21];
	end

	always_comb begin
		prdata = '0;	// Unmapped and write-only offsets read zero
		if (rd_result && !res_empty) begin
			prdata[31]   = 1'b1;	// Entry valid
			prdata[16]   = res_data.taken;
			prdata[15:8] = res_data.flags;
			prdata[7:0]  = res_data.value;
		end else if (rd_status) begin
			prdata[sm83_alu_pkg::FIFO_CNT_W-1:0]  = cmd_count;
			prdata[8 +: sm83_alu_pkg::FIFO_CNT_W] = res_count;
		end
	end

	// Master side protocol
	apb_penable_with_psel: assert property (@(posedge clk) disable iff (reset)
		penable |-> psel)
		else $error("alu_apb_regs: penable high without psel");

	apb_setup_then_access: assert property (@(posedge clk) disable iff (reset)
		psel && !penable |=> psel && penable)
		else $error("alu_apb_regs: setup phase not followed by access phase");

endmodule

`default_nettype wire

/* hw/alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_core (
	input  logic                   clk,
	input  logic                   reset,
	input  sm83_alu_pkg::alu_cmd_t cmd_data,	// Head of the command FIFO
	input  logic                   cmd_empty,
	output logic                   cmd_pop,
	output logic                   res_push,
	output sm83_alu_pkg::alu_res_t res_data,	// Output register
	input  logic                   res_full
);

	logic [7:0] flags_q;	// Z N H C in the high nibble
	logic       out_valid;	// res_data holds an unpushed entry
	logic       fz;
	logic       fn;
	logic       fh;
	logic       fc;
	logic [7:0] add_b;
	logic       add_cin;
	logic [7:0] sum;
	logic       half;
	logic       carry;
	logic [7:0] shift_out;
	logic       shift_cout;
	logic       daa_lo;	// Low nibble needs 0x06
	logic       daa_hi;	// High nibble needs 0x60 and sets C
	logic [7:0] daa_corr;
	logic [7:0] bit_mask;
	logic [7:0] value;
	logic       z;
	logic       n;
	logic       h;
	logic       c;
	logic       taken;
	logic [7:0] new_flags;

	assign fz = flags_q[sm83_alu_pkg::FLAG_Z];
	assign fn = flags_q[sm83_alu_pkg::FLAG_N];
	assign fh = flags_q[sm83_alu_pkg::FLAG_H];
	assign fc = flags_q[sm83_alu_pkg::FLAG_C];

	assign daa_lo   = fh | (~fn & (cmd_data.a[3:0] > 4'd9));
	assign daa_hi   = fc | (~fn & (cmd_data.a > 8'h99));
	assign daa_corr = {1'b0, daa_hi, daa_hi, 2'b00, daa_lo, daa_lo, 1'b0};
	assign bit_mask = 8'b1 << cmd_data.sel;

	// Adder operands with subtract as A + ~B + 1
	always_comb begin
		add_b   = cmd_data.b;
		add_cin = 1'b0;
		case (cmd_data.op)
			sm83_alu_pkg::OP_ADC: add_cin = fc;
			sm83_alu_pkg::OP_SUB, sm83_alu_pkg::OP_CP: begin
				add_b   = ~cmd_data.b;
				add_cin = 1'b1;
			end
			sm83_alu_pkg::OP_SBC: begin
				add_b   = ~cmd_data.b;
				add_cin = ~fc;	// Borrow in
			end
			sm83_alu_pkg::OP_INC: add_b = 8'h01;
			sm83_alu_pkg::OP_DEC: begin
				add_b   = 8'hFE;	// ~1
				add_cin = 1'b1;
			end
			sm83_alu_pkg::OP_DAA: begin
				add_b   = fn ? ~daa_corr : daa_corr;	// Correction added or subtracted
				add_cin = fn;
			end
			default: add_b = cmd_data.b;
		endcase
	end

	alu_adder_cla u_adder (.a(cmd_data.a), .b(add_b), .cin(add_cin),
		.sum(sum), .half_carry(half), .carry(carry));

	alu_shifter u_shifter (.op(cmd_data.op), .din(cmd_data.a), .cin(fc),
		.dout(shift_out), .cout(shift_cout));

	always_comb begin
		value = cmd_data.a;	// Default returns A with flags kept
		z     = fz;
		n     = fn;
		h     = fh;
		c     = fc;
		taken = 1'b0;
		case (cmd_data.op)
			sm83_alu_pkg::OP_ADD, sm83_alu_pkg::OP_ADC: begin
				value = sum;
				z     = (sum == 8'h00);
				n     = 1'b0;
				h     = half;
				c     = carry;
			end
			sm83_alu_pkg::OP_SUB, sm83_alu_pkg::OP_SBC, sm83_alu_pkg::OP_CP: begin
				if (cmd_data.op != sm83_alu_pkg::OP_CP)
					value = sum;	// CP only compares
				z = (sum == 8'h00);
				n = 1'b1;
				h = ~half;	// Carries inverted into borrows
				c = ~carry;
			end
			sm83_alu_pkg::OP_AND: begin
				value = cmd_data.a & cmd_data.b;
				z     = (value == 8'h00);
				n     = 1'b0;
				h     = 1'b1;
				c     = 1'b0;
			end
			sm83_alu_pkg::OP_XOR, sm83_alu_pkg::OP_OR: begin
				value = (cmd_data.op == sm83_alu_pkg::OP_XOR) ? cmd_data.a ^ cmd_data.b
					: cmd_data.a | cmd_data.b;
				z     = (value == 8'h00);
				n     = 1'b0;
				h     = 1'b0;
				c     = 1'b0;
			end
			sm83_alu_pkg::OP_INC, sm83_alu_pkg::OP_DEC: begin
				value = sum;
				z     = (sum == 8'h00);
				n     = (cmd_data.op == sm83_alu_pkg::OP_DEC);
				h     = n ? ~half : half;	// C untouched
			end
			sm83_alu_pkg::OP_RLC, sm83_alu_pkg::OP_RRC, sm83_alu_pkg::OP_RL,
			sm83_alu_pkg::OP_RR, sm83_alu_pkg::OP_SLA, sm83_alu_pkg::OP_SRA,
			sm83_alu_pkg::OP_SWAP, sm83_alu_pkg::OP_SRL: begin
				value = shift_out;
				z     = (shift_out == 8'h00);
				n     = 1'b0;
				h     = 1'b0;
				c     = shift_cout;
			end
			sm83_alu_pkg::OP_BIT: begin
				z = ~cmd_data.a[cmd_data.sel];
				n = 1'b0;
				h = 1'b1;
			end
			sm83_alu_pkg::OP_SET: value = cmd_data.a | bit_mask;
			sm83_alu_pkg::OP_RES: value = cmd_data.a & ~bit_mask;
			sm83_alu_pkg::OP_DAA: begin
				value = sum;
				z     = (sum == 8'h00);
				h     = 1'b0;
				c     = daa_hi;
			end
			sm83_alu_pkg::OP_CPL: begin
				value = ~cmd_data.a;
				n     = 1'b1;
				h     = 1'b1;
			end
			sm83_alu_pkg::OP_SCF, sm83_alu_pkg::OP_CCF: begin
				n = 1'b0;
				h = 1'b0;
				c = (cmd_data.op == sm83_alu_pkg::OP_SCF) | ~fc;
			end
			sm83_alu_pkg::OP_CC: begin
				case (cmd_data.sel[1:0])
					sm83_alu_pkg::CC_NZ: taken = ~fz;
					sm83_alu_pkg::CC_Z:  taken = fz;
					sm83_alu_pkg::CC_NC: taken = ~fc;
					sm83_alu_pkg::CC_C:  taken = fc;
					default:             taken = 1'b0;
				endcase
			end
			sm83_alu_pkg::OP_LDF: begin
				z = cmd_data.a[sm83_alu_pkg::FLAG_Z];	// Same bit layout as the flag byte
				n = cmd_data.a[sm83_alu_pkg::FLAG_N];
				h = cmd_data.a[sm83_alu_pkg::FLAG_H];
				c = cmd_data.a[sm83_alu_pkg::FLAG_C];
			end
			default: value = cmd_data.a;
		endcase
	end

	always_comb begin
		new_flags                      = 8'h00;
		new_flags[sm83_alu_pkg::FLAG_Z] = z;
		new_flags[sm83_alu_pkg::FLAG_N] = n;
		new_flags[sm83_alu_pkg::FLAG_H] = h;
		new_flags[sm83_alu_pkg::FLAG_C] = c;
	end

	assign res_push = out_valid & ~res_full;
	assign cmd_pop  = ~cmd_empty & (~out_valid | ~res_full);	// Room now or after drain

	always_ff @(posedge clk) begin
		if (reset) begin
			flags_q   <= 8'h00;
			out_valid <= 1'b0;
		end else if (cmd_pop) begin
			flags_q   <= new_flags;	// Flags move only on a pop
			out_valid <= 1'b1;
		end else if (res_push) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_pop) begin
			res_data.value <= value;
			res_data.flags <= new_flags;
			res_data.taken <= taken;
		end
	end

	// A stalled entry must survive until the result FIFO frees up
	core_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		out_valid && res_full |=> out_valid && $stable(res_data))
		else $error("alu_core: pending result changed while stalled");

endmodule

`default_nettype wire

/* hw/alu_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_fifo #(
	parameter type payload_t = logic [7:0]
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                push,
	input  payload_t                            push_data,
	output logic                                full,
	input  logic                                pop,
	output payload_t                            pop_data,	// Head entry, valid when not empty
	output logic                                empty,
	output logic [sm83_alu_pkg::FIFO_CNT_W-1:0] count
);

	payload_t mem [sm83_alu_pkg::FIFO_DEPTH];	// Circular storage
	logic [sm83_alu_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [sm83_alu_pkg::FIFO_PTR_W-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign do_push  = push & ~full;	// Dropped when full
	assign do_pop   = pop & ~empty;
	assign full     = (count == sm83_alu_pkg::FIFO_FULL_CNT);
	assign empty    = (count == '0);
	assign pop_data = mem[rd_ptr];	// Show-ahead read

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;	// Power of two depth, no wrap logic
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// Idle or simultaneous push and pop
			endcase
		end
	end

	// Producer must watch full, consumer must watch empty
	fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
		!(push && full && !pop))
		else $error("alu_fifo: push while full, entry lost");

	fifo_no_underflow: assert property (@(posedge clk) disable iff (reset)
		!(pop && empty))
		else $error("alu_fifo: pop while empty");

endmodule

`default_nettype wire

/* hw/alu_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_shifter (
	input  sm83_alu_pkg::alu_op_e op,
	input  logic [7:0]            din,
	input  logic                  cin,	// Old C flag for RL and RR
	output logic [7:0]            dout,
	output logic                  cout
);

	always_comb begin
		dout = din;	// Pass through for non-shift ops
		cout = 1'b0;
		case (op)
			sm83_alu_pkg::OP_RLC: begin
				dout = {din[6:0], din[7]};	// Bit 7 wraps into bit 0
				cout = din[7];
			end
			sm83_alu_pkg::OP_RRC: begin
				dout = {din[0], din[7:1]};	// Bit 0 wraps into bit 7
				cout = din[0];
			end
			sm83_alu_pkg::OP_RL: begin
				dout = {din[6:0], cin};	// Rotate through carry
				cout = din[7];
			end
			sm83_alu_pkg::OP_RR: begin
				dout = {cin, din[7:1]};
				cout = din[0];
			end
			sm83_alu_pkg::OP_SLA: begin
				dout = {din[6:0], 1'b0};
				cout = din[7];
			end
			sm83_alu_pkg::OP_SRA: begin
				dout = {din[7], din[7:1]};	// Sign bit kept
				cout = din[0];
			end
			sm83_alu_pkg::OP_SRL: begin
				dout = {1'b0, din[7:1]};
				cout = din[0];
			end
			sm83_alu_pkg::OP_SWAP: begin
				dout = {din[3:0], din[7:4]};	// Nibble exchange
				cout = 1'b0;	// SWAP always clears C
			end
			default: dout = din;
		endcase
	end

endmodule

`default_nettype wire

/* hw/alu_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_subsystem_top (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [sm83_alu_pkg::APB_ADDR_W-1:0] paddr,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [sm83_alu_pkg::APB_DATA_W-1:0] pwdata,
	output logic [sm83_alu_pkg::APB_DATA_W-1:0] prdata,
	output logic                                pready,
	output logic                                pslverr
);

	// Command path, register block to core
	logic                                cmd_push;
	sm83_alu_pkg::alu_cmd_t              cmd_wdata;
	logic                                cmd_full;
	logic [sm83_alu_pkg::FIFO_CNT_W-1:0] cmd_count;
	logic                                cmd_pop;
	sm83_alu_pkg::alu_cmd_t              cmd_rdata;
	logic                                cmd_empty;

	// Result path, core to register block
	logic                                res_push;
	sm83_alu_pkg::alu_res_t              res_wdata;
	logic                                res_full;
	logic [sm83_alu_pkg::FIFO_CNT_W-1:0] res_count;
	logic                                res_pop;
	sm83_alu_pkg::alu_res_t              res_rdata;
	logic                                res_empty;

	alu_apb_regs u_apb_regs (.clk(clk), .reset(reset), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .cmd_push(cmd_push), .cmd_data(cmd_wdata),
		.cmd_full(cmd_full), .cmd_count(cmd_count), .res_pop(res_pop),
		.res_data(res_rdata), .res_empty(res_empty), .res_count(res_count));

	alu_fifo #(.payload_t(sm83_alu_pkg::alu_cmd_t)) u_cmd_fifo (.clk(clk), .reset(reset),
		.push(cmd_push), .push_data(cmd_wdata), .full(cmd_full), .pop(cmd_pop),
		.pop_data(cmd_rdata), .empty(cmd_empty), .count(cmd_count));

	alu_fifo #(.payload_t(sm83_alu_pkg::alu_res_t)) u_res_fifo (.clk(clk), .reset(reset),
		.push(res_push), .push_data(res_wdata), .full(res_full), .pop(res_pop),
		.pop_data(res_rdata), .empty(res_empty), .count(res_count));

	alu_core u_alu_core (.clk(clk), .reset(reset), .cmd_data(cmd_rdata),
		.cmd_empty(cmd_empty), .cmd_pop(cmd_pop), .res_push(res_push),
		.res_data(res_wdata), .res_full(res_full));

endmodule

`default_nettype wire

/* hw/sm83_alu_pkg.sv */
`default_nettype none

package sm83_alu_pkg;

	localparam int APB_ADDR_W = 4;	// Byte offset into the register window
	localparam int APB_DATA_W = 32;

	localparam int FIFO_DEPTH = 4;	// Same depth for commands and results
	localparam int FIFO_PTR_W = 2;	// Wraps naturally at FIFO_DEPTH
	localparam int FIFO_CNT_W = 3;	// 0..FIFO_DEPTH
	localparam logic [FIFO_CNT_W-1:0] FIFO_FULL_CNT = FIFO_CNT_W'(FIFO_DEPTH);

	// Flag byte layout, low nibble reads zero
	localparam int FLAG_Z = 7;
	localparam int FLAG_N = 6;
	localparam int FLAG_H = 5;
	localparam int FLAG_C = 4;

	localparam logic [APB_ADDR_W-1:0] REG_CMD    = 4'h0;	// Write only, pushes a command
	localparam logic [APB_ADDR_W-1:0] REG_RESULT = 4'h4;	// Read pops a result
	localparam logic [APB_ADDR_W-1:0] REG_STATUS = 4'h8;	// Both fill counts

	// Condition codes in sel[1:0] for CC
	localparam logic [1:0] CC_NZ = 2'b00;
	localparam logic [1:0] CC_Z  = 2'b01;
	localparam logic [1:0] CC_NC = 2'b10;
	localparam logic [1:0] CC_C  = 2'b11;

	typedef enum logic [4:0] {
		OP_ADD, OP_ADC, OP_SUB, OP_SBC, OP_CP,	// Adder group
		OP_AND, OP_XOR, OP_OR,
		OP_INC, OP_DEC,
		OP_RLC, OP_RRC, OP_RL, OP_RR,	// Shifter group
		OP_SLA, OP_SRA, OP_SWAP, OP_SRL,
		OP_BIT, OP_SET, OP_RES,	// Bit index in sel
		OP_DAA, OP_CPL, OP_SCF, OP_CCF,
		OP_CC,	// Condition check, flags untouched
		OP_LDF	// Flags from A[7:4]
	} alu_op_e;

	typedef struct packed {
		alu_op_e    op;
		logic [7:0] a;	// Operand A, also the shifter and bit-op source
		logic [7:0] b;
		logic [2:0] sel;	// Bit index or condition code
	} alu_cmd_t;

	typedef struct packed {
		logic [7:0] value;
		logic [7:0] flags;	// Z N H C 0 0 0 0
		logic       taken;	// CC outcome, zero for other ops
	} alu_res_t;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the ALU subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f compile.f \
	--top-module tb_alu_subsystem -o sim_alu_subsystem \
	|| { echo "Verilator build failed"; exit 1; }

out="$(./obj_dir/sim_alu_subsystem)"
echo "$out"
echo "$out" | grep -q "Regression passed" && exit 0 || exit 1

/* test/tb_alu_vectors.svh */
// Columns: name, flags loaded by LDF, op, A, B, sel,
// expected value, expected flags, expected taken
task automatic load_vectors();
	add_vector("add_carry_zero", 8'h00, sm83_alu_pkg::OP_ADD, 8'h3A, 8'hC6, 3'd0, 8'h00, 8'hB0, 1'b0);
	add_vector("add_plain", 8'h00, sm83_alu_pkg::OP_ADD, 8'h12, 8'h34, 3'd0, 8'h46, 8'h00, 1'b0);
	add_vector("adc_c_in", 8'h10, sm83_alu_pkg::OP_ADC, 8'hE1, 8'h0F, 3'd0, 8'hF1, 8'h20, 1'b0);
	add_vector("adc_no_c", 8'h00, sm83_alu_pkg::OP_ADC, 8'hE1, 8'h0F, 3'd0, 8'hF0, 8'h20, 1'b0);
	add_vector("sub_zero", 8'h00, sm83_alu_pkg::OP_SUB, 8'h3E, 8'h3E, 3'd0, 8'h00, 8'hC0, 1'b0);
	add_vector("sub_borrow", 8'h00, sm83_alu_pkg::OP_SUB, 8'h3E, 8'h40, 3'd0, 8'hFE, 8'h50, 1'b0);
	add_vector("sub_half", 8'h00, sm83_alu_pkg::OP_SUB, 8'h3E, 8'h0F, 3'd0, 8'h2F, 8'h60, 1'b0);
	add_vector("sbc_c_in", 8'h10, sm83_alu_pkg::OP_SBC, 8'h3B, 8'h2A, 3'd0, 8'h10, 8'h40, 1'b0);
	add_vector("sbc_borrow", 8'h10, sm83_alu_pkg::OP_SBC, 8'h3B, 8'h4F, 3'd0, 8'hEB, 8'h70, 1'b0);
	add_vector("cp_equal", 8'h00, sm83_alu_pkg::OP_CP, 8'h3C, 8'h3C, 3'd0, 8'h3C, 8'hC0, 1'b0);
	add_vector("cp_less", 8'h00, sm83_alu_pkg::OP_CP, 8'h3C, 8'h40, 3'd0, 8'h3C, 8'h50, 1'b0);
	// Logic group
	add_vector("and_zero", 8'h10, sm83_alu_pkg::OP_AND, 8'h5A, 8'hA5, 3'd0, 8'h00, 8'hA0, 1'b0);
	add_vector("and_plain", 8'h00, sm83_alu_pkg::OP_AND, 8'hF0, 8'h3C, 3'd0, 8'h30, 8'h20, 1'b0);
	add_vector("xor_self", 8'hF0, sm83_alu_pkg::OP_XOR, 8'hFF, 8'hFF, 3'd0, 8'h00, 8'h80, 1'b0);
	add_vector("or_plain", 8'h70, sm83_alu_pkg::OP_OR, 8'h0F, 8'h30, 3'd0, 8'h3F, 8'h00, 1'b0);
	add_vector("inc_keep_c", 8'h10, sm83_alu_pkg::OP_INC, 8'hFF, 8'h00, 3'd0, 8'h00, 8'hB0, 1'b0);
	add_vector("inc_half", 8'h00, sm83_alu_pkg::OP_INC, 8'h4F, 8'h00, 3'd0, 8'h50, 8'h20, 1'b0);
	add_vector("dec_zero", 8'h10, sm83_alu_pkg::OP_DEC, 8'h01, 8'h00, 3'd0, 8'h00, 8'hD0, 1'b0);
	add_vector("dec_half", 8'h00, sm83_alu_pkg::OP_DEC, 8'h10, 8'h00, 3'd0, 8'h0F, 8'h60, 1'b0);
	// Shifter, RL and RR take the preset carry
	add_vector("rlc", 8'h00, sm83_alu_pkg::OP_RLC, 8'h85, 8'h00, 3'd0, 8'h0B, 8'h10, 1'b0);
	add_vector("rrc", 8'h00, sm83_alu_pkg::OP_RRC, 8'h01, 8'h00, 3'd0, 8'h80, 8'h10, 1'b0);
	add_vector("rl_c_in", 8'h10, sm83_alu_pkg::OP_RL, 8'h80, 8'h00, 3'd0, 8'h01, 8'h10, 1'b0);
	add_vector("rl_zero", 8'h00, sm83_alu_pkg::OP_RL, 8'h80, 8'h00, 3'd0, 8'h00, 8'h90, 1'b0);
	add_vector("rr_c_in", 8'h10, sm83_alu_pkg::OP_RR, 8'h01, 8'h00, 3'd0, 8'h80, 8'h10, 1'b0);
	add_vector("sla", 8'h00, sm83_alu_pkg::OP_SLA, 8'hFF, 8'h00, 3'd0, 8'hFE, 8'h10, 1'b0);
	add_vector("sra_sign", 8'h00, sm83_alu_pkg::OP_SRA, 8'h8A, 8'h00, 3'd0, 8'hC5, 8'h00, 1'b0);
	add_vector("srl_zero", 8'h00, sm83_alu_pkg::OP_SRL, 8'h01, 8'h00, 3'd0, 8'h00, 8'h90, 1'b0);
	add_vector("swap", 8'h10, sm83_alu_pkg::OP_SWAP, 8'hF0, 8'h00, 3'd0, 8'h0F, 8'h00, 1'b0);
	add_vector("swap_zero", 8'h00, sm83_alu_pkg::OP_SWAP, 8'h00, 8'h00, 3'd0, 8'h00, 8'h80, 1'b0);
	// Bit ops, sel is the bit index
	add_vector("bit7_set", 8'h10, sm83_alu_pkg::OP_BIT, 8'h80, 8'h00, 3'd7, 8'h80, 8'h30, 1'b0);
	add_vector("bit0_clear", 8'h40, sm83_alu_pkg::OP_BIT, 8'hFE, 8'h00, 3'd0, 8'hFE, 8'hA0, 1'b0);
	add_vector("set3", 8'hF0, sm83_alu_pkg::OP_SET, 8'h00, 8'h00, 3'd3, 8'h08, 8'hF0, 1'b0);
	add_vector("res7", 8'h00, sm83_alu_pkg::OP_RES, 8'hFF, 8'h00, 3'd7, 8'h7F, 8'h00, 1'b0);
	add_vector("daa_add", 8'h00, sm83_alu_pkg::OP_DAA, 8'h3C, 8'h00, 3'd0, 8'h42, 8'h00, 1'b0);
	add_vector("daa_carry", 8'h00, sm83_alu_pkg::OP_DAA, 8'h9A, 8'h00, 3'd0, 8'h00, 8'h90, 1'b0);
	add_vector("daa_sub", 8'h60, sm83_alu_pkg::OP_DAA, 8'h0F, 8'h00, 3'd0, 8'h09, 8'h40, 1'b0);
	add_vector("cpl", 8'h90, sm83_alu_pkg::OP_CPL, 8'h35, 8'h00, 3'd0, 8'hCA, 8'hF0, 1'b0);
	add_vector("scf", 8'hE0, sm83_alu_pkg::OP_SCF, 8'h12, 8'h00, 3'd0, 8'h12, 8'h90, 1'b0);
	add_vector("ccf_clear", 8'h70, sm83_alu_pkg::OP_CCF, 8'h12, 8'h00, 3'd0, 8'h12, 8'h00, 1'b0);
	add_vector("ccf_set", 8'h80, sm83_alu_pkg::OP_CCF, 8'h12, 8'h00, 3'd0, 8'h12, 8'h90, 1'b0);
	// Condition checks, code in sel[1:0]
	add_vector("cc_nz_taken", 8'h00, sm83_alu_pkg::OP_CC, 8'h55, 8'h00, 3'd0, 8'h55, 8'h00, 1'b1);
	add_vector("cc_nz_not", 8'h80, sm83_alu_pkg::OP_CC, 8'h55, 8'h00, 3'd0, 8'h55, 8'h80, 1'b0);
	add_vector("cc_z_taken", 8'h80, sm83_alu_pkg::OP_CC, 8'h55, 8'h00, 3'd1, 8'h55, 8'h80, 1'b1);
	add_vector("cc_nc_taken", 8'h00, sm83_alu_pkg::OP_CC, 8'h55, 8'h00, 3'd2, 8'h55, 8'h00, 1'b1);
	add_vector("cc_nc_not", 8'h10, sm83_alu_pkg::OP_CC, 8'h55, 8'h00, 3'd2, 8'h55, 8'h10, 1'b0);
	add_vector("cc_c_taken", 8'h10, sm83_alu_pkg::OP_CC, 8'h55, 8'h00, 3'd3, 8'h55, 8'h10, 1'b1);
	add_vector("cc_c_not", 8'hE0, sm83_alu_pkg::OP_CC, 8'h55, 8'h00, 3'd3, 8'h55, 8'hE0, 1'b0);
endtask

/* test/tb_alu_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_alu_subsystem;

	localparam int POLL_LIMIT = 20;	// Status reads before giving up
	localparam int RANDOM_OPS = 200;

	logic        clk;
	logic        reset;
	logic [3:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;

	int          value_errors;	// Wrong data read back
	int          other_errors;	// Timeouts and bus errors
	logic [31:0] lfsr;

	string       vec_name[$];
	logic [7:0]  vec_flags[$];	// Loaded through LDF before the op
	logic [4:0]  vec_op[$];
	logic [7:0]  vec_a[$];
	logic [7:0]  vec_b[$];
	logic [2:0]  vec_sel[$];
	logic [16:0] vec_exp[$];	// {value, flags, taken}

	alu_subsystem_top u_alu_subsystem_top (.clk(clk), .reset(reset), .paddr(paddr),
		.psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr));

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;	// 20 ns period
	end

	task automatic add_vector(input string name, input logic [7:0] flags_in,
		input logic [4:0] op, input logic [7:0] a, input logic [7:0] b, input logic [2:0] sel,
		input logic [7:0] exp_val, input logic [7:0] exp_flags, input logic exp_taken);
		vec_name.push_back(name);
		vec_flags.push_back(flags_in);
		vec_op.push_back(op);
		vec_a.push_back(a);
		vec_b.push_back(b);
		vec_sel.push_back(sel);
		vec_exp.push_back({exp_val, exp_flags, exp_taken});
	endtask

	`include "tb_alu_vectors.svh"

	// REG_CMD layout
	function automatic logic [31:0] cmd_word(input logic [4:0] op, input logic [7:0] a,
		input logic [7:0] b, input logic [2:0] sel);
		return {8'h00, sel, op, b, a};
	endfunction

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_byte(output logic [7:0] v);
		v = 8'h00;
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[6:0], lfsr[0]};	// One step per bit
		end
	endtask

	// Reference for ADD, SUB and XOR
	function automatic logic [16:0] model_result(input logic [4:0] op, input logic [7:0] a,
		input logic [7:0] b);
		logic [8:0] wide;
		logic [7:0] v;
		logic [7:0] f;
		f = 8'h00;
		if (op == sm83_alu_pkg::OP_ADD) begin
			wide = {1'b0, a} + {1'b0, b};
			v    = wide[7:0];
			f[sm83_alu_pkg::FLAG_H] = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'h0F;
			f[sm83_alu_pkg::FLAG_C] = wide[8];
		end else if (op == sm83_alu_pkg::OP_SUB) begin
			v = a - b;
			f[sm83_alu_pkg::FLAG_N] = 1'b1;
			f[sm83_alu_pkg::FLAG_H] = a[3:0] < b[3:0];	// Borrow from bit 4
			f[sm83_alu_pkg::FLAG_C] = a < b;
		end else begin
			v = a ^ b;
		end
		f[sm83_alu_pkg::FLAG_Z] = (v == 8'h00);
		return {v, f, 1'b0};
	endfunction

	task automatic apb_transfer(input logic write, input logic [3:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		#2;
		paddr   = addr;
		pwrite  = write;
		pwdata  = wdata;
		psel    = 1'b1;
		penable = 1'b0;	// Setup phase
		@(posedge clk);
		#2;
		penable = 1'b1;
		@(negedge clk);	// Access phase outputs settled
		rdata = prdata;
		err   = pslverr;
		if (!pready) begin
			$display("pready was low during an access phase");
			other_errors++;
		end
		@(posedge clk);
		#2;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic send_cmd(input string name, input logic [31:0] word);
		logic [31:0] rd;
		logic        err;
		apb_transfer(1'b1, sm83_alu_pkg::REG_CMD, word, rd, err);
		if (err) begin
			$display("%s: command write was rejected with pslverr", name);
			other_errors++;
		end
	endtask

	task automatic fetch_result(input string name, output logic [31:0] rd);
		logic [31:0] st;
		logic        err;
		int          polls;
		st    = 32'h0;
		polls = 0;
		while (st[10:8] == 3'd0 && polls < POLL_LIMIT) begin	// Result count
			apb_transfer(1'b0, sm83_alu_pkg::REG_STATUS, 32'h0, st, err);
			polls++;
		end
		if (st[10:8] == 3'd0) begin
			$display("%s: timed out waiting for a result entry", name);
			other_errors++;
		end
		apb_transfer(1'b0, sm83_alu_pkg::REG_RESULT, 32'h0, rd, err);
		if (st[10:8] != 3'd0 && !rd[31]) begin
			$display("%s: result read came back without the valid bit", name);
			other_errors++;
		end
	endtask

	task automatic check_result(input string name, input logic [31:0] rd,
		input logic [16:0] exp);
		logic [16:0] got;
		got = {rd[7:0], rd[15:8], rd[16]};
		if (got != exp) begin
			$display("** Error %s: expected %02h/%02h/%0d, got %02h/%02h/%0d (value/flags/taken)",
				name, exp[16:9], exp[8:1], exp[0], got[16:9], got[8:1], got[0]);
			value_errors++;
		end
	endtask

	task automatic run_command(input string name, input logic [31:0] word,
		input logic [16:0] exp);
		logic [31:0] rd;
		send_cmd(name, word);
		fetch_result(name, rd);
		check_result(name, rd, exp);
	endtask

	initial begin
		logic [31:0] rd;
		logic        err;
		logic [7:0]  ra;
		logic [7:0]  rb;
		logic [4:0]  rop;
		int          n_cmds;
		int          n_err;
		int          err_idx;
		value_errors = 0;
		other_errors = 0;
		lfsr         = 32'd74361;
		reset        = 1'b1;
		paddr        = 4'h0;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		pwdata       = 32'h0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		apb_transfer(1'b0, sm83_alu_pkg::REG_STATUS, 32'h0, rd, err);	// Both FIFOs empty
		if (rd != 32'h0) begin
			$display("** Error reset_status: expected %08h, got %08h", 32'h0, rd);
			value_errors++;
		end
		run_command("reset_cc_z", cmd_word(sm83_alu_pkg::OP_CC, 8'h5A, 8'h00, 3'd1),
			{8'h5A, 8'h00, 1'b0});	// Z cleared, not taken

		load_vectors();
		foreach (vec_name[i]) begin
			send_cmd(vec_name[i], cmd_word(sm83_alu_pkg::OP_LDF, vec_flags[i], 8'h00, 3'd0));
			send_cmd(vec_name[i], cmd_word(vec_op[i], vec_a[i], vec_b[i], vec_sel[i]));
			fetch_result(vec_name[i], rd);	// LDF entry dropped
			fetch_result(vec_name[i], rd);
			check_result(vec_name[i], rd, vec_exp[i]);
		end

		for (int i = 0; i < RANDOM_OPS; i++) begin
			draw_byte(ra);
			draw_byte(rb);
			case (i % 3)
				0:       rop = sm83_alu_pkg::OP_ADD;
				1:       rop = sm83_alu_pkg::OP_SUB;
				default: rop = sm83_alu_pkg::OP_XOR;
			endcase
			run_command($sformatf("random_%0d", i), cmd_word(rop, ra, rb, 3'd0),
				model_result(rop, ra, rb));
		end

		// Both FIFOs full plus one entry parked in the core
		n_cmds  = 2 * sm83_alu_pkg::FIFO_DEPTH + 2;
		n_err   = 0;
		err_idx = -1;
		for (int i = 0; i < n_cmds; i++) begin
			apb_transfer(1'b1, sm83_alu_pkg::REG_CMD,
				cmd_word(sm83_alu_pkg::OP_OR, 8'(i + 1), 8'h00, 3'd0), rd, err);
			if (err) begin
				n_err++;
				err_idx = i;
			end
		end
		if (n_err != 1 || err_idx != n_cmds - 1) begin
			$display("Overflow: expected one pslverr on the last write, saw %0d", n_err);
			other_errors++;
		end
		for (int i = 0; i < n_cmds - 1; i++) begin
			fetch_result("overflow_order", rd);	// Write order expected
			check_result("overflow_order", rd, {8'(i + 1), 8'h00, 1'b0});
		end
		apb_transfer(1'b0, sm83_alu_pkg::REG_RESULT, 32'h0, rd, err);
		if (rd != 32'h0) begin
			$display("** Error empty_read: expected %08h, got %08h", 32'h0, rd);
			value_errors++;
		end

		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
